//--- design/blur_3x3.sv
`timescale 1ns/1ps

module blur_3x3
  import blur_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic calc,       // capture strobe
  input  row_t row_1,      // row above center
  input  row_t row_2,      // center row
  input  row_t row_3,      // row below center
  output row_t blur_row    // registered 3x3 result
);

  logic [9:0]  col_sum [0:img_cols+1];   // vertical 1-2-1, one zero column each side
  logic [11:0] h_sum   [0:img_cols-1];   // full 2d sum, max 16 * 255
  row_t        blur_next;

  // vertical pass
  always_comb begin
    col_sum[0]          = '0;            // left of column 0
    col_sum[img_cols+1] = '0;            // right of last column
    for (int c = 0; c < img_cols; c++) begin
      col_sum[c+1] = 10'(row_1[c*pix_w +: pix_w])
                   + 10'(row_2[c*pix_w +: pix_w]) * 10'd2
                   + 10'(row_3[c*pix_w +: pix_w]);
    end
  end

  // horizontal pass, then round half up and divide by 16
  always_comb begin
    for (int c = 0; c < img_cols; c++) begin
      h_sum[c] = 12'(col_sum[c])
               + 12'(col_sum[c+1]) * 12'd2
               + 12'(col_sum[c+2]);
      blur_next[c*pix_w +: pix_w] = pix_t'((h_sum[c] + 12'd8) >> 4);  // max 255
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur_row <= '0;
    end else if (calc) begin
      blur_row <= blur_next;
    end
  end

endmodule

//--- design/blur_5x5.sv
`timescale 1ns/1ps

module blur_5x5
  import blur_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic calc,       // capture strobe
  input  row_t row_0,      // oldest row
  input  row_t row_1,
  input  row_t row_2,      // center row
  input  row_t row_3,
  input  row_t row_4,      // newest row
  output row_t blur_row    // registered 5x5 result
);

  logic [11:0] col_sum [0:img_cols+3];   // vertical 1-4-6-4-1, two zero columns each side
  logic [15:0] h_sum   [0:img_cols-1];   // full 2d sum, max 256 * 255
  row_t        blur_next;

  // vertical pass first, separable kernel
  always_comb begin
    col_sum[0]          = '0;            // two columns left of the image
    col_sum[1]          = '0;
    col_sum[img_cols+2] = '0;            // two columns right of the image
    col_sum[img_cols+3] = '0;
    for (int c = 0; c < img_cols; c++) begin
      col_sum[c+2] = 12'(row_0[c*pix_w +: pix_w])
                   + 12'(row_1[c*pix_w +: pix_w]) * 12'd4
                   + 12'(row_2[c*pix_w +: pix_w]) * 12'd6
                   + 12'(row_3[c*pix_w +: pix_w]) * 12'd4
                   + 12'(row_4[c*pix_w +: pix_w]);
    end
  end

  // horizontal pass over the column sums
  always_comb begin
    for (int c = 0; c < img_cols; c++) begin
      h_sum[c] = 16'(col_sum[c])                // column c - 2
               + 16'(col_sum[c+1]) * 16'd4
               + 16'(col_sum[c+2]) * 16'd6      // column c itself
               + 16'(col_sum[c+3]) * 16'd4
               + 16'(col_sum[c+4]);             // column c + 2
    end
  end

  // round half up, divide by 256
  always_comb begin
    for (int c = 0; c < img_cols; c++) begin
      blur_next[c*pix_w +: pix_w] = pix_t'((h_sum[c] + 16'd128) >> 8);  // 65408 max, no wrap
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur_row <= '0;
    end else if (calc) begin
      blur_row <= blur_next;
    end
  end

endmodule

//--- design/blur_ctrl.sv
`timescale 1ns/1ps

module blur_ctrl
  import blur_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start,       // one-cycle pulse while idle
  output logic      done,        // one-cycle pulse after last write
  output logic      buffer_we,   // shift strobe to the line buffer
  output logic      fill_zero,   // shift in a zero row instead of img_addr
  output logic      calc,        // kernels capture this cycle
  output logic      wr,          // writeback captures this cycle
  output row_addr_t img_addr     // image row to load next
);

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  row_addr_t   load_cnt;         // rows shifted in this frame
  logic        last_row;
  logic        center_ok;

  // all image rows plus the bottom padding have gone through
  assign last_row  = (load_cnt == row_addr_t'(img_rows + pad_rows));

  // center of the window holds image row load_cnt - 3 from here on
  assign center_ok = (load_cnt >= row_addr_t'(win_rows / 2 + 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;                     // hold by default
    case (state)
      st_idle: begin
        if (start) begin
          state_nxt = st_ready;
        end
      end
      st_ready: state_nxt = st_load;       // single settle cycle
      st_load:  state_nxt = st_calc;
      st_calc:  state_nxt = st_write;
      st_write: begin
        if (last_row) begin
          state_nxt = st_idle;             // frame finished
        end else begin
          state_nxt = st_load;             // next row
        end
      end
      default:  state_nxt = st_idle;
    endcase
  end

  // load counter, cleared on the way into a frame
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      load_cnt <= '0;
    end else if (state == st_ready) begin
      load_cnt <= '0;
    end else if (state == st_load) begin
      load_cnt <= load_cnt + row_addr_t'(1);
    end
  end

  // image row address, parks at img_rows during padding
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      img_addr <= '0;
    end else if (done) begin
      img_addr <= '0;                      // back to top for next frame
    end else if (state == st_load && img_addr < row_addr_t'(img_rows)) begin
      img_addr <= img_addr + row_addr_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else begin
      done <= (state == st_write) && last_row;   // lands with the return to idle
    end
  end

  assign buffer_we = (state == st_load);
  assign fill_zero = buffer_we && (load_cnt >= row_addr_t'(img_rows));  // past bottom edge
  assign calc      = (state == st_calc);
  assign wr        = (state == st_write) && center_ok;  // skip the window fill rows

endmodule

//--- design/blur_pkg.sv
package blur_pkg;

  // image geometry
  localparam int pix_w    = 8;                 // bits per pixel
  localparam int img_cols = 8;                 // pixels per row
  localparam int img_rows = 8;                 // rows per frame
  localparam int row_w    = pix_w * img_cols;  // one packed row
  localparam int addr_w   = 4;                 // row address, covers img_rows + pad_rows

  // line buffer window
  localparam int win_rows = 5;                 // rows held by the outside line buffer
  localparam int pad_rows = 2;                 // zero rows shifted in past the bottom

  // pixel and row carriers
  typedef logic [pix_w-1:0]  pix_t;            // one grayscale pixel
  typedef logic [row_w-1:0]  row_t;            // pixel 0 in the low bits
  typedef logic [addr_w-1:0] row_addr_t;       // image or result memory row

  // frame controller
  typedef enum logic [2:0] {
    st_idle  = 3'd0,                           // waiting for start
    st_ready = 3'd1,                           // one cycle for the memories to settle
    st_load  = 3'd2,                           // shift a row into the window
    st_calc  = 3'd3,                           // both kernels register
    st_write = 3'd4                            // hand results to writeback
  } ctrl_state_t;

endpackage

//--- design/blur_writeback.sv
`timescale 1ns/1ps

module blur_writeback
  import blur_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      wr,             // capture strobe from the controller
  input  row_t      blur_row_3x3,
  input  row_t      blur_row_5x5,
  output logic      blur_we,        // shared write enable, both result memories
  output row_addr_t blur_addr,      // shared result row
  output row_t      blur_din_0,     // 3x3 result word
  output row_t      blur_din_1      // 5x5 result word
);

  logic last_addr;

  assign last_addr = (blur_addr == row_addr_t'(img_rows - 1));  // bottom result row

  // data word pair, held until the next capture
  always_ff @(posedge clk) begin
    if (wr) begin
      blur_din_0 <= blur_row_3x3;
      blur_din_1 <= blur_row_5x5;
    end
  end

  // write lands one cycle after capture
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur_we <= 1'b0;
    end else begin
      blur_we <= wr;
    end
  end

  // address steps after each write, wraps for next frame
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur_addr <= '0;
    end else if (blur_we) begin
      if (last_addr) begin
        blur_addr <= '0;
      end else begin
        blur_addr <= blur_addr + row_addr_t'(1);
      end
    end
  end

endmodule

//--- design/gauss_blur_top.sv
`timescale 1ns/1ps

module gauss_blur_top
  import blur_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start,        // frame start pulse
  input  row_t      row_0,        // line buffer, oldest
  input  row_t      row_1,
  input  row_t      row_2,        // line buffer, center
  input  row_t      row_3,
  input  row_t      row_4,        // line buffer, newest
  output logic      done,
  output logic      buffer_we,
  output logic      fill_zero,
  output logic      blur_we,
  output row_addr_t img_addr,
  output row_addr_t blur_addr,
  output row_t      blur_din_0,   // 3x3 result
  output row_t      blur_din_1    // 5x5 result
);

  logic calc;                     // kernel capture
  logic wr;                       // writeback capture
  row_t blur_row_3x3;
  row_t blur_row_5x5;

  blur_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .done      (done),
    .buffer_we (buffer_we),
    .fill_zero (fill_zero),
    .calc      (calc),
    .wr        (wr),
    .img_addr  (img_addr)
  );

  blur_3x3 u_blur_3x3 (
    .clk      (clk),
    .rst_n    (rst_n),
    .calc     (calc),
    .row_1    (row_1),
    .row_2    (row_2),
    .row_3    (row_3),
    .blur_row (blur_row_3x3)
  );

  blur_5x5 u_blur_5x5 (
    .clk      (clk),
    .rst_n    (rst_n),
    .calc     (calc),
    .row_0    (row_0),
    .row_1    (row_1),
    .row_2    (row_2),
    .row_3    (row_3),
    .row_4    (row_4),
    .blur_row (blur_row_5x5)
  );

  blur_writeback u_writeback (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr           (wr),
    .blur_row_3x3 (blur_row_3x3),
    .blur_row_5x5 (blur_row_5x5),
    .blur_we      (blur_we),
    .blur_addr    (blur_addr),
    .blur_din_0   (blur_din_0),
    .blur_din_1   (blur_din_1)
  );

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the gaussian blur testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module tb_gauss_blur \
  -f sources.f \
  -o tb_gauss_blur_sim

# the simulator exits non-zero on a failed check, the search below decides
sim_out="$(./obj_dir/tb_gauss_blur_sim 2>&1 || true)"
echo "$sim_out"

if grep -qx "Test passed" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi

//--- sources.f
+incdir+tests
design/blur_pkg.sv
design/blur_ctrl.sv
design/blur_3x3.sv
design/blur_5x5.sv
design/blur_writeback.sv
design/gauss_blur_top.sv
tests/tb_gauss_blur.sv

//--- tests/tb_blur_model.svh
`ifndef TB_BLUR_MODEL_SVH
`define TB_BLUR_MODEL_SVH

// 32-bit fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  logic fb;
  fb = s[31] ^ s[21] ^ s[1] ^ s[0];
  return {s[30:0], fb};
endfunction

// one lfsr step per pixel bit
function automatic pix_t random_pixel();
  pix_t p;
  p = '0;
  for (int i = 0; i < pix_w; i++) begin
    lfsr_state = lfsr_next(lfsr_state);
    p = {p[pix_w-2:0], lfsr_state[0]};
  end
  return p;
endfunction

// source pixel, zero on all four sides of the frame
function automatic int pixel_at(input int r, input int c);
  if (r < 0 || r >= img_rows || c < 0 || c >= img_cols) begin
    return 0;
  end
  return int'(img_mem[r][c*pix_w +: pix_w]);
endfunction

function automatic int weight_3(input int d);
  return (d == 0) ? 2 : 1;                 // 1-2-1
endfunction

function automatic int weight_5(input int d);
  if (d == 0) begin
    return 6;
  end
  if (d == 1 || d == -1) begin
    return 4;
  end
  return 1;                                // outer taps of 1-4-6-4-1
endfunction

// direct 2d sum, round half up, /16
function automatic row_t expect_row_3x3(input int r);
  row_t res_row;
  int   sum;
  res_row = '0;
  for (int c = 0; c < img_cols; c++) begin
    sum = 0;
    for (int dr = -1; dr <= 1; dr++) begin
      for (int dc = -1; dc <= 1; dc++) begin
        sum += weight_3(dr) * weight_3(dc) * pixel_at(r + dr, c + dc);
      end
    end
    res_row[c*pix_w +: pix_w] = pix_t'((sum + 8) >> 4);
  end
  return res_row;
endfunction

// direct 2d sum, round half up, /256
function automatic row_t expect_row_5x5(input int r);
  row_t res_row;
  int   sum;
  res_row = '0;
  for (int c = 0; c < img_cols; c++) begin
    sum = 0;
    for (int dr = -2; dr <= 2; dr++) begin
      for (int dc = -2; dc <= 2; dc++) begin
        sum += weight_5(dr) * weight_5(dc) * pixel_at(r + dr, c + dc);
      end
    end
    res_row[c*pix_w +: pix_w] = pix_t'((sum + 128) >> 8);
  end
  return res_row;
endfunction

`endif

//--- tests/tb_gauss_blur.sv
`timescale 1ns/1ps

module tb_gauss_blur
  import blur_pkg::*;
();

  localparam int frame_loads    = img_rows + pad_rows;        // buffer_we pulses per frame
  localparam int frame_cycles   = 40;                         // 3 per row plus start and drain
  localparam int frame_count    = 5;                          // flat, impulse, random, two b2b
  localparam int timeout_cycles = frame_count * frame_cycles;

  logic      clk;
  logic      rst_n;
  logic      start;
  logic      done;
  logic      buffer_we;
  logic      fill_zero;
  logic      blur_we;
  row_addr_t img_addr;
  row_addr_t blur_addr;
  row_t      blur_din_0;
  row_t      blur_din_1;

  row_t        win     [0:win_rows-1];     // line buffer window, win[0] oldest
  row_t        img_mem [0:img_rows-1];     // source image
  row_t        res_3x3 [0:img_rows-1];     // result memory 0
  row_t        res_5x5 [0:img_rows-1];     // result memory 1
  logic [31:0] lfsr_state;
  int          cycle_cnt;
  int          load_total;                 // running counts over the whole run
  int          write_total;
  int          done_total;

  `include "tb_blur_model.svh"

  gauss_blur_top u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .row_0      (win[0]),
    .row_1      (win[1]),
    .row_2      (win[2]),
    .row_3      (win[3]),
    .row_4      (win[4]),
    .done       (done),
    .buffer_we  (buffer_we),
    .fill_zero  (fill_zero),
    .blur_we    (blur_we),
    .img_addr   (img_addr),
    .blur_addr  (blur_addr),
    .blur_din_0 (blur_din_0),
    .blur_din_1 (blur_din_1)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;                 // 4 ns period
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [63:0] expected,
                          input logic [63:0] actual);
    if (expected !== actual) begin
      fail_now($sformatf("mismatch %s: expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic step();
    @(posedge clk);
    #1;                                    // drive and sample just after the edge
  endtask

  initial begin
    cycle_cnt = 0;
    forever begin
      @(posedge clk);
      cycle_cnt++;
      if (cycle_cnt >= timeout_cycles) begin
        fail_now($sformatf("run did not finish within %0d cycles", timeout_cycles));
      end
    end
  end

  // line buffer, shift sampled mid cycle and applied 1 ns past the edge
  initial begin : line_buffer_model
    logic do_shift;
    logic do_zero;
    logic do_clear;
    int   src_row;
    for (int i = 0; i < win_rows; i++) begin
      win[i] = '0;
    end
    forever begin
      @(negedge clk);
      do_shift = rst_n && buffer_we;
      do_zero  = fill_zero;
      do_clear = start;                    // fresh window each frame
      src_row  = int'(img_addr);
      @(posedge clk);
      #1;
      if (do_clear) begin
        for (int i = 0; i < win_rows; i++) begin
          win[i] = '0;
        end
      end else if (do_shift) begin
        for (int i = 0; i < win_rows - 1; i++) begin
          win[i] = win[i+1];
        end
        win[win_rows-1] = do_zero ? '0 : img_mem[src_row];
      end
    end
  end

  // result memories plus load and write sequencing
  initial begin : output_monitor
    int idx;
    load_total  = 0;
    write_total = 0;
    done_total  = 0;
    forever begin
      @(negedge clk);
      if (rst_n) begin
        if (buffer_we) begin
          idx = load_total % frame_loads;
          if (idx < img_rows) begin
            check_eq("load fill_zero", 64'(1'b0), 64'(fill_zero));
            check_eq("load img_addr", 64'(idx), 64'(img_addr));
          end else begin
            check_eq("pad fill_zero", 64'(1'b1), 64'(fill_zero));
          end
          load_total++;
        end
        if (blur_we) begin
          check_eq("write order", 64'(write_total % img_rows), 64'(blur_addr));
          idx = int'(blur_addr);
          res_3x3[idx] = blur_din_0;
          res_5x5[idx] = blur_din_1;
          write_total++;
        end
        if (done) begin
          done_total++;
        end
      end
    end
  end

  task automatic fill_value(input pix_t v);
    for (int r = 0; r < img_rows; r++) begin
      for (int c = 0; c < img_cols; c++) begin
        img_mem[r][c*pix_w +: pix_w] = v;
      end
    end
  endtask

  task automatic fill_random();
    for (int r = 0; r < img_rows; r++) begin
      for (int c = 0; c < img_cols; c++) begin
        img_mem[r][c*pix_w +: pix_w] = random_pixel();
      end
    end
  endtask

  task automatic fill_gradient();
    for (int r = 0; r < img_rows; r++) begin
      for (int c = 0; c < img_cols; c++) begin
        img_mem[r][c*pix_w +: pix_w] = pix_t'(r * 32 + c * 4);  // max 252
      end
    end
  endtask

  // one start pulse, wait for done, then frame bookkeeping
  task automatic run_frame(input string name);
    int loads_before;
    int writes_before;
    int dones_before;
    loads_before  = load_total;
    writes_before = write_total;
    dones_before  = done_total;
    start = 1'b1;
    step();
    start = 1'b0;
    while (!done) begin
      step();                              // watchdog bounds this
    end
    step();                                // last write shares the done cycle
    check_eq($sformatf("%s done low", name), 64'(1'b0), 64'(done));
    check_eq($sformatf("%s loads", name), 64'(frame_loads), 64'(load_total - loads_before));
    check_eq($sformatf("%s writes", name), 64'(img_rows), 64'(write_total - writes_before));
    check_eq($sformatf("%s done pulses", name), 64'(1), 64'(done_total - dones_before));
    check_eq($sformatf("%s img_addr rewound", name), 64'(0), 64'(img_addr));
    check_eq($sformatf("%s blur_addr wrapped", name), 64'(0), 64'(blur_addr));
  endtask

  task automatic compare_results(input string name);
    for (int r = 0; r < img_rows; r++) begin
      check_eq($sformatf("%s 3x3 row %0d", name, r), 64'(expect_row_3x3(r)), 64'(res_3x3[r]));
      check_eq($sformatf("%s 5x5 row %0d", name, r), 64'(expect_row_5x5(r)), 64'(res_5x5[r]));
    end
  endtask

  task automatic test_reset();
    check_eq("reset done", 64'(1'b0), 64'(done));
    check_eq("reset buffer_we", 64'(1'b0), 64'(buffer_we));
    check_eq("reset fill_zero", 64'(1'b0), 64'(fill_zero));
    check_eq("reset blur_we", 64'(1'b0), 64'(blur_we));
    check_eq("reset img_addr", 64'(0), 64'(img_addr));
    check_eq("reset blur_addr", 64'(0), 64'(blur_addr));
  endtask

  task automatic test_flat();
    fill_value(pix_t'(100));
    run_frame("flat");
    compare_results("flat");
    check_eq("flat 3x3 interior", 64'(100), 64'(res_3x3[3][3*pix_w +: pix_w]));
    check_eq("flat 5x5 interior", 64'(100), 64'(res_5x5[3][3*pix_w +: pix_w]));
    check_eq("flat 3x3 corner below 100", 64'(1'b1),
             64'(res_3x3[0][pix_w-1:0] < pix_t'(100)));
    check_eq("flat 5x5 edge below 100", 64'(1'b1),
             64'(res_5x5[3][pix_w-1:0] < pix_t'(100)));
  endtask

  // single 255 at (3,3), results must be the scaled kernels
  task automatic test_impulse();
    int dr;
    int dc;
    int exp3;
    int exp5;
    fill_value(pix_t'(0));
    img_mem[3][3*pix_w +: pix_w] = pix_t'(255);
    run_frame("impulse");
    for (int r = 0; r < img_rows; r++) begin
      for (int c = 0; c < img_cols; c++) begin
        dr   = r - 3;
        dc   = c - 3;
        exp3 = 0;
        exp5 = 0;
        if (dr >= -1 && dr <= 1 && dc >= -1 && dc <= 1) begin
          exp3 = (255 * weight_3(dr) * weight_3(dc) + 8) >> 4;
        end
        if (dr >= -2 && dr <= 2 && dc >= -2 && dc <= 2) begin
          exp5 = (255 * weight_5(dr) * weight_5(dc) + 128) >> 8;
        end
        check_eq($sformatf("impulse 3x3 r%0d c%0d", r, c), 64'(exp3),
                 64'(res_3x3[r][c*pix_w +: pix_w]));
        check_eq($sformatf("impulse 5x5 r%0d c%0d", r, c), 64'(exp5),
                 64'(res_5x5[r][c*pix_w +: pix_w]));
      end
    end
  endtask

  task automatic test_random();
    fill_random();
    run_frame("random");
    compare_results("random");
  endtask

  // second start right after done, different image
  task automatic test_back_to_back();
    fill_random();
    run_frame("b2b first");
    compare_results("b2b first");
    fill_gradient();
    run_frame("b2b second");
    compare_results("b2b second");
  endtask

  initial begin
    lfsr_state = 32'hcf59_8e88;
    rst_n      = 1'b0;
    start      = 1'b0;
    fill_value(pix_t'(0));
    repeat (2) step();                     // two reset cycles
    rst_n = 1'b1;
    test_reset();
    test_flat();
    test_impulse();
    test_random();
    test_back_to_back();
    $display("Test passed");
    $finish;
  end

endmodule
